//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP       := tb_cl_hello_world
FILELIST  := tb.f
RUN_ARGS  := +verilator+error+limit+100
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/cl_hello_pkg.sv
// Shared by RTL and testbench. Offsets are byte addresses on the 32-bit AXI-Lite bus with no base decode
package cl_hello_pkg;

  // ------------------------------
  // Bus and port widths
  // ------------------------------
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int vled_w = 16;

  // ------------------------------
  // Register map
  // ------------------------------
  // Stores a word, reads back byte-reversed
  localparam logic [addr_w-1:0] hello_addr      = 32'h0000_0500;
  // Read only, shadows hello[15:0]
  localparam logic [addr_w-1:0] vled_addr       = 32'h0000_0504;
  // Bit 0 enable, bit 1 clear pulse, bit 2 one-shot
  localparam logic [addr_w-1:0] cnt_ctrl_addr   = 32'h0000_0508;
  localparam logic [addr_w-1:0] tick_val_addr   = 32'h0000_050C;
  // Write loads the main counter
  localparam logic [addr_w-1:0] cnt_load_addr   = 32'h0000_0510;
  localparam logic [addr_w-1:0] watermark_addr  = 32'h0000_0514;
  // Count, prescaler and watermark flag, read only
  localparam logic [addr_w-1:0] cnt_status_addr = 32'h0000_0518;

  // Filler for unmapped reads
  localparam logic [data_w-1:0] unimpl_value = 32'hDEAD_DEAD;

  // AXI response code
  localparam logic [1:0] resp_okay = 2'b00;

  // ------------------------------
  // FSM states
  // ------------------------------
  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_e;

  typedef enum logic [1:0] {
    rd_idle,
    rd_fetch,
    rd_resp
  } rd_state_e;

endpackage

//--- hw/cl_hello_world.sv
// Top level of the hello-world block. Clock and reset come in already synchronous, no register slice
`timescale 1ns/1ps

module cl_hello_world #(
  parameter int CNT_W  = 16,
  parameter int TICK_W = 8
) (
  input  logic                                clk_main_a0,
  input  logic                                rst_main_n_sync,

  input  logic                                sh_ocl_awvalid,
  input  logic [cl_hello_pkg::addr_w-1:0]     sh_ocl_awaddr,
  output logic                                ocl_sh_awready,
  input  logic                                sh_ocl_wvalid,
  input  logic [cl_hello_pkg::data_w-1:0]     sh_ocl_wdata,
  input  logic [cl_hello_pkg::data_w/8-1:0]   sh_ocl_wstrb,
  output logic                                ocl_sh_wready,
  output logic                                ocl_sh_bvalid,
  output logic [1:0]                          ocl_sh_bresp,
  input  logic                                sh_ocl_bready,
  input  logic                                sh_ocl_arvalid,
  input  logic [cl_hello_pkg::addr_w-1:0]     sh_ocl_araddr,
  output logic                                ocl_sh_arready,
  output logic                                ocl_sh_rvalid,
  output logic [cl_hello_pkg::data_w-1:0]     ocl_sh_rdata,
  output logic [1:0]                          ocl_sh_rresp,
  input  logic                                sh_ocl_rready,

  input  logic [cl_hello_pkg::vled_w-1:0]     sh_cl_status_vdip,
  output logic [cl_hello_pkg::vled_w-1:0]     cl_sh_status_vled
);

  // Slave to register block
  logic                            reg_wr_en;
  logic [cl_hello_pkg::addr_w-1:0] reg_wr_addr;
  logic [cl_hello_pkg::data_w-1:0] reg_wr_data;
  logic [cl_hello_pkg::addr_w-1:0] rd_addr;
  logic [cl_hello_pkg::data_w-1:0] rd_data;

  // Register block to counter
  logic              cnt_enable;
  logic              cnt_oneshot;
  logic              cnt_clear;
  logic              cnt_load;
  logic [CNT_W-1:0]  cnt_load_value;
  logic [TICK_W-1:0] tick_value;
  logic [CNT_W-1:0]  cnt_watermark;
  logic [CNT_W-1:0]  cnt_value;
  logic [TICK_W-1:0] tick_cnt;
  logic              cnt_ge_watermark;

  ocl_slave ocl_slave_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (sh_ocl_awvalid),
    .awaddr          (sh_ocl_awaddr),
    .awready         (ocl_sh_awready),
    .wvalid          (sh_ocl_wvalid),
    .wdata           (sh_ocl_wdata),
    .wstrb           (sh_ocl_wstrb),
    .wready          (ocl_sh_wready),
    .bvalid          (ocl_sh_bvalid),
    .bresp           (ocl_sh_bresp),
    .bready          (sh_ocl_bready),
    .arvalid         (sh_ocl_arvalid),
    .araddr          (sh_ocl_araddr),
    .arready         (ocl_sh_arready),
    .rvalid          (ocl_sh_rvalid),
    .rdata           (ocl_sh_rdata),
    .rresp           (ocl_sh_rresp),
    .rready          (sh_ocl_rready),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  hello_regs #(
    .CNT_W  (CNT_W),
    .TICK_W (TICK_W)
  ) hello_regs_inst (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .reg_wr_en        (reg_wr_en),
    .reg_wr_addr      (reg_wr_addr),
    .reg_wr_data      (reg_wr_data),
    .rd_addr          (rd_addr),
    .rd_data          (rd_data),
    .status_vdip      (sh_cl_status_vdip),
    .status_vled      (cl_sh_status_vled),
    .cnt_enable       (cnt_enable),
    .cnt_oneshot      (cnt_oneshot),
    .cnt_clear        (cnt_clear),
    .cnt_load         (cnt_load),
    .cnt_load_value   (cnt_load_value),
    .tick_value       (tick_value),
    .cnt_watermark    (cnt_watermark),
    .cnt_value        (cnt_value),
    .tick_cnt         (tick_cnt),
    .cnt_ge_watermark (cnt_ge_watermark)
  );

  tick_counter #(
    .CNT_W  (CNT_W),
    .TICK_W (TICK_W)
  ) tick_counter_inst (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .cnt_enable       (cnt_enable),
    .cnt_oneshot      (cnt_oneshot),
    .cnt_clear        (cnt_clear),
    .cnt_load         (cnt_load),
    .cnt_load_value   (cnt_load_value),
    .tick_value       (tick_value),
    .cnt_watermark    (cnt_watermark),
    .cnt_value        (cnt_value),
    .tick_cnt         (tick_cnt),
    .cnt_ge_watermark (cnt_ge_watermark)
  );

endmodule

//--- hw/hello_regs.sv
// Status word packs count at bit 0, tick_cnt at bit 16 and the flag at bit 24, so CNT_W<=16 and TICK_W<=8
`timescale 1ns/1ps

module hello_regs #(
  parameter int CNT_W  = 16,
  parameter int TICK_W = 8
) (
  input  logic                                clk_main_a0,
  input  logic                                rst_main_n_sync,

  // Bus slave side
  input  logic                                reg_wr_en,
  input  logic [cl_hello_pkg::addr_w-1:0]     reg_wr_addr,
  input  logic [cl_hello_pkg::data_w-1:0]     reg_wr_data,
  input  logic [cl_hello_pkg::addr_w-1:0]     rd_addr,
  output logic [cl_hello_pkg::data_w-1:0]     rd_data,

  // Virtual DIP and LED
  input  logic [cl_hello_pkg::vled_w-1:0]     status_vdip,
  output logic [cl_hello_pkg::vled_w-1:0]     status_vled,

  // Counter control and status
  output logic                                cnt_enable,
  output logic                                cnt_oneshot,
  output logic                                cnt_clear,
  output logic                                cnt_load,
  output logic [CNT_W-1:0]                    cnt_load_value,
  output logic [TICK_W-1:0]                   tick_value,
  output logic [CNT_W-1:0]                    cnt_watermark,
  input  logic [CNT_W-1:0]                    cnt_value,
  input  logic [TICK_W-1:0]                   tick_cnt,
  input  logic                                cnt_ge_watermark
);

  localparam int stat_tick_lsb = 16;
  localparam int stat_ge_bit   = 24;

  logic [cl_hello_pkg::data_w-1:0] hello_q;
  logic [cl_hello_pkg::vled_w-1:0] vled_q;
  logic [cl_hello_pkg::vled_w-1:0] vdip_q;
  logic [cl_hello_pkg::vled_w-1:0] vdip_q2;
  logic                            wr_ctrl;
  logic                            wr_load;

  assign wr_ctrl = reg_wr_en && (reg_wr_addr == cl_hello_pkg::cnt_ctrl_addr);
  assign wr_load = reg_wr_en && (reg_wr_addr == cl_hello_pkg::cnt_load_addr);

  // ------------------------------
  // Writable registers
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q       <= '0;
      cnt_enable    <= 1'b0;
      cnt_oneshot   <= 1'b0;
      cnt_clear     <= 1'b0;
      cnt_load      <= 1'b0;
      tick_value    <= '0;
      cnt_watermark <= '0;
    end else begin
      // Pulses follow the write by one cycle
      cnt_clear <= wr_ctrl && reg_wr_data[1];
      cnt_load  <= wr_load;
      if (reg_wr_en && (reg_wr_addr == cl_hello_pkg::hello_addr)) begin
        hello_q <= reg_wr_data;
      end
      if (wr_ctrl) begin
        cnt_enable  <= reg_wr_data[0];
        cnt_oneshot <= reg_wr_data[2];
      end
      if (reg_wr_en && (reg_wr_addr == cl_hello_pkg::tick_val_addr)) begin
        tick_value <= reg_wr_data[TICK_W-1:0];
      end
      if (reg_wr_en && (reg_wr_addr == cl_hello_pkg::watermark_addr)) begin
        cnt_watermark <= reg_wr_data[CNT_W-1:0];
      end
    end
  end

  // Only meaningful alongside cnt_load
  always_ff @(posedge clk_main_a0) begin
    if (wr_load) begin
      cnt_load_value <= reg_wr_data[CNT_W-1:0];
    end
  end

  // ------------------------------
  // Virtual LED path
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q      <= '0;
      vdip_q      <= '0;
      vdip_q2     <= '0;
      status_vled <= '0;
    end else begin
      vled_q      <= hello_q[cl_hello_pkg::vled_w-1:0];
      // Two-flop synchronizer on the DIP input
      vdip_q      <= status_vdip;
      vdip_q2     <= vdip_q;
      status_vled <= vled_q & vdip_q2;
    end
  end

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    rd_data = '0;
    unique case (rd_addr)
      cl_hello_pkg::hello_addr: begin
        rd_data = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};
      end
      cl_hello_pkg::vled_addr: begin
        rd_data[cl_hello_pkg::vled_w-1:0] = vled_q;
      end
      cl_hello_pkg::cnt_ctrl_addr: begin
        // Clear bit is a pulse and reads as 0
        rd_data[0] = cnt_enable;
        rd_data[2] = cnt_oneshot;
      end
      cl_hello_pkg::tick_val_addr: begin
        rd_data[TICK_W-1:0] = tick_value;
      end
      cl_hello_pkg::cnt_load_addr: begin
        // Write only
        rd_data = '0;
      end
      cl_hello_pkg::watermark_addr: begin
        rd_data[CNT_W-1:0] = cnt_watermark;
      end
      cl_hello_pkg::cnt_status_addr: begin
        rd_data[CNT_W-1:0]                  = cnt_value;
        rd_data[stat_tick_lsb +: TICK_W]    = tick_cnt;
        rd_data[stat_ge_bit]                = cnt_ge_watermark;
      end
      default: rd_data = cl_hello_pkg::unimpl_value;
    endcase
  end

endmodule

//--- hw/ocl_slave.sv
// Single-beat AXI-Lite only. wstrb is ignored, full words are written and every response is OKAY
`timescale 1ns/1ps

module ocl_slave (
  input  logic                                clk_main_a0,
  input  logic                                rst_main_n_sync,

  // Write address channel
  input  logic                                awvalid,
  input  logic [cl_hello_pkg::addr_w-1:0]     awaddr,
  output logic                                awready,

  // Write data channel
  input  logic                                wvalid,
  input  logic [cl_hello_pkg::data_w-1:0]     wdata,
  input  logic [cl_hello_pkg::data_w/8-1:0]   wstrb,
  output logic                                wready,

  // Write response channel
  output logic                                bvalid,
  output logic [1:0]                          bresp,
  input  logic                                bready,

  // Read address channel
  input  logic                                arvalid,
  input  logic [cl_hello_pkg::addr_w-1:0]     araddr,
  output logic                                arready,

  // Read data channel
  output logic                                rvalid,
  output logic [cl_hello_pkg::data_w-1:0]     rdata,
  output logic [1:0]                          rresp,
  input  logic                                rready,

  // Register block side
  output logic                                reg_wr_en,
  output logic [cl_hello_pkg::addr_w-1:0]     reg_wr_addr,
  output logic [cl_hello_pkg::data_w-1:0]     reg_wr_data,
  output logic [cl_hello_pkg::addr_w-1:0]     rd_addr,
  input  logic [cl_hello_pkg::data_w-1:0]     rd_data
);

  cl_hello_pkg::wr_state_e wr_state;
  cl_hello_pkg::rd_state_e rd_state;

  logic [cl_hello_pkg::addr_w-1:0] wr_addr_q;
  logic [cl_hello_pkg::addr_w-1:0] rd_addr_q;

  // ------------------------------
  // Write channel
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= cl_hello_pkg::wr_idle;
    end else begin
      unique case (wr_state)
        cl_hello_pkg::wr_idle: begin
          if (awvalid) begin
            wr_state <= cl_hello_pkg::wr_data;
          end
        end
        cl_hello_pkg::wr_data: begin
          if (wvalid) begin
            wr_state <= cl_hello_pkg::wr_resp;
          end
        end
        cl_hello_pkg::wr_resp: begin
          if (bready) begin
            wr_state <= cl_hello_pkg::wr_idle;
          end
        end
        default: wr_state <= cl_hello_pkg::wr_idle;
      endcase
    end
  end

  // Address held for the data phase
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr_q <= awaddr;
    end
  end

  assign awready = (wr_state == cl_hello_pkg::wr_idle);
  assign wready  = (wr_state == cl_hello_pkg::wr_data) && wvalid;
  assign bvalid  = (wr_state == cl_hello_pkg::wr_resp);
  assign bresp   = cl_hello_pkg::resp_okay;

  // Registers update on the data handshake edge
  assign reg_wr_en   = wvalid && wready;
  assign reg_wr_addr = wr_addr_q;
  assign reg_wr_data = wdata;

  // ------------------------------
  // Read channel
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state <= cl_hello_pkg::rd_idle;
      rdata    <= '0;
    end else begin
      unique case (rd_state)
        cl_hello_pkg::rd_idle: begin
          if (arvalid) begin
            rd_state <= cl_hello_pkg::rd_fetch;
          end
        end
        cl_hello_pkg::rd_fetch: begin
          // Mux output is settled from the latched address
          rdata    <= rd_data;
          rd_state <= cl_hello_pkg::rd_resp;
        end
        cl_hello_pkg::rd_resp: begin
          if (rready) begin
            rd_state <= cl_hello_pkg::rd_idle;
          end
        end
        default: rd_state <= cl_hello_pkg::rd_idle;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr_q <= araddr;
    end
  end

  assign arready = (rd_state == cl_hello_pkg::rd_idle);
  assign rvalid  = (rd_state == cl_hello_pkg::rd_resp);
  assign rresp   = cl_hello_pkg::resp_okay;
  assign rd_addr = rd_addr_q;

endmodule

//--- hw/tick_counter.sv
// Clear wins over load, load over enable. One-shot saturates at all ones instead of wrapping
`timescale 1ns/1ps

module tick_counter #(
  parameter int CNT_W  = 16,
  parameter int TICK_W = 8
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              cnt_enable,
  input  logic              cnt_oneshot,
  input  logic              cnt_clear,
  input  logic              cnt_load,
  input  logic [CNT_W-1:0]  cnt_load_value,
  input  logic [TICK_W-1:0] tick_value,
  input  logic [CNT_W-1:0]  cnt_watermark,
  output logic [CNT_W-1:0]  cnt_value,
  output logic [TICK_W-1:0] tick_cnt,
  output logic              cnt_ge_watermark
);

  logic tick;
  logic at_max;

  // Prescaler period is tick_value+1 cycles
  assign tick   = (tick_cnt >= tick_value);
  assign at_max = &cnt_value;

  // ------------------------------
  // Prescaler
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt <= '0;
    end else if (cnt_clear) begin
      tick_cnt <= '0;
    end else if (cnt_enable) begin
      if (tick) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // ------------------------------
  // Main counter
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt_value <= '0;
    end else if (cnt_clear) begin
      cnt_value <= '0;
    end else if (cnt_load) begin
      cnt_value <= cnt_load_value;
    end else if (cnt_enable && tick) begin
      // Hold at the top in one-shot mode
      if (!(cnt_oneshot && at_max)) begin
        cnt_value <= cnt_value + 1'b1;
      end
    end
  end

  // Compare lags the count by one cycle
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt_ge_watermark <= 1'b0;
    end else begin
      cnt_ge_watermark <= (cnt_value >= cnt_watermark);
    end
  end

endmodule

//--- tb.f
hw/cl_hello_pkg.sv
hw/ocl_slave.sv
hw/hello_regs.sv
hw/tick_counter.sv
hw/cl_hello_world.sv
testbench/cl_hello_world_assertions.sv
testbench/tb_cl_hello_world.sv

//--- testbench/cl_hello_world_assertions.sv
// Bound into the top level; handshake checks are off during reset, the awready check is not
`timescale 1ns/1ps

module cl_hello_world_assertions (
  input logic        clk_main_a0,
  input logic        rst_main_n_sync,
  input logic        ocl_sh_awready,
  input logic        ocl_sh_bvalid,
  input logic        sh_ocl_bready,
  input logic        ocl_sh_rvalid,
  input logic        sh_ocl_rready,
  input logic [31:0] ocl_sh_rdata
);

  int unsigned fail_cnt = 0;

  // Responses stay up until taken
  bvalid_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_sh_bvalid && !sh_ocl_bready |=> ocl_sh_bvalid)
    else begin
      fail_cnt++;
      $error("bvalid dropped before bready");
    end

  rvalid_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_sh_rvalid && !sh_ocl_rready |=> ocl_sh_rvalid)
    else begin
      fail_cnt++;
      $error("rvalid dropped before rready");
    end

  rdata_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ocl_sh_rvalid && !sh_ocl_rready |=> $stable(ocl_sh_rdata))
    else begin
      fail_cnt++;
      $error("rdata changed while the read response was stalled");
    end

  awready_after_reset: assert property (@(posedge clk_main_a0)
    !rst_main_n_sync |=> ocl_sh_awready)
    else begin
      fail_cnt++;
      $error("awready low one cycle after reset");
    end

endmodule

bind cl_hello_world cl_hello_world_assertions cl_hello_world_assertions_inst (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .ocl_sh_awready  (ocl_sh_awready),
  .ocl_sh_bvalid   (ocl_sh_bvalid),
  .sh_ocl_bready   (sh_ocl_bready),
  .ocl_sh_rvalid   (ocl_sh_rvalid),
  .sh_ocl_rready   (sh_ocl_rready),
  .ocl_sh_rdata    (ocl_sh_rdata)
);

//--- testbench/tb_cl_hello_world.sv
// Drives only the AXI-Lite port and the DIP input; counter checks assume no wrap between two reads
`timescale 1ns/1ps

module tb_cl_hello_world;

  localparam int timeout_cycles = 100;
  localparam int flag_awready   = 0;
  localparam int flag_wready    = 1;
  localparam int flag_bvalid    = 2;
  localparam int flag_arready   = 3;
  localparam int flag_rvalid    = 4;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  logic        sh_ocl_awvalid;
  logic [31:0] sh_ocl_awaddr;
  logic        ocl_sh_awready;
  logic        sh_ocl_wvalid;
  logic [31:0] sh_ocl_wdata;
  logic [3:0]  sh_ocl_wstrb;
  logic        ocl_sh_wready;
  logic        ocl_sh_bvalid;
  logic [1:0]  ocl_sh_bresp;
  logic        sh_ocl_bready;
  logic        sh_ocl_arvalid;
  logic [31:0] sh_ocl_araddr;
  logic        ocl_sh_arready;
  logic        ocl_sh_rvalid;
  logic [31:0] ocl_sh_rdata;
  logic [1:0]  ocl_sh_rresp;
  logic        sh_ocl_rready;
  logic [15:0] sh_cl_status_vdip;
  logic [15:0] cl_sh_status_vled;

  logic [31:0] rng_state;
  int unsigned mismatch_cnt;
  int unsigned timeout_cnt;

  // Reference model state
  logic [31:0] model_hello;
  logic [15:0] model_dip;
  logic [15:0] model_watermark;

  cl_hello_world cl_hello_world_inst (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .sh_ocl_awvalid    (sh_ocl_awvalid),
    .sh_ocl_awaddr     (sh_ocl_awaddr),
    .ocl_sh_awready    (ocl_sh_awready),
    .sh_ocl_wvalid     (sh_ocl_wvalid),
    .sh_ocl_wdata      (sh_ocl_wdata),
    .sh_ocl_wstrb      (sh_ocl_wstrb),
    .ocl_sh_wready     (ocl_sh_wready),
    .ocl_sh_bvalid     (ocl_sh_bvalid),
    .ocl_sh_bresp      (ocl_sh_bresp),
    .sh_ocl_bready     (sh_ocl_bready),
    .sh_ocl_arvalid    (sh_ocl_arvalid),
    .sh_ocl_araddr     (sh_ocl_araddr),
    .ocl_sh_arready    (ocl_sh_arready),
    .ocl_sh_rvalid     (ocl_sh_rvalid),
    .ocl_sh_rdata      (ocl_sh_rdata),
    .ocl_sh_rresp      (ocl_sh_rresp),
    .sh_ocl_rready     (sh_ocl_rready),
    .sh_cl_status_vdip (sh_cl_status_vdip),
    .cl_sh_status_vled (cl_sh_status_vled)
  );

  initial clk_main_a0 = 1'b0;
  always #50 clk_main_a0 = ~clk_main_a0;

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Byte k of the result is byte 3-k of the input
  function automatic logic [31:0] byte_swap(input logic [31:0] v);
    logic [31:0] out;
    int k;
    out = '0;
    for (k = 0; k < 4; k++) begin
      out[8*k +: 8] = v[8*(3-k) +: 8];
    end
    return out;
  endfunction

  function automatic logic is_mapped(input logic [31:0] a);
    return (a == 32'h500) || (a == 32'h504) || (a == 32'h508) || (a == 32'h50C) ||
           (a == 32'h510) || (a == 32'h514) || (a == 32'h518);
  endfunction

  function automatic logic flag_high(input int which);
    case (which)
      flag_awready: return ocl_sh_awready;
      flag_wready:  return ocl_sh_wready;
      flag_bvalid:  return ocl_sh_bvalid;
      flag_arready: return ocl_sh_arready;
      flag_rvalid:  return ocl_sh_rvalid;
      default:      return 1'b0;
    endcase
  endfunction

  // Returns at a falling edge with the flag high, or after the timeout
  task automatic wait_flag(input int which, input string name);
    int n;
    n = 0;
    @(negedge clk_main_a0);
    while (!flag_high(which) && n < timeout_cycles) begin
      @(negedge clk_main_a0);
      n++;
    end
    if (!flag_high(which)) begin
      $display("Timeout at %0t: %s stayed low for %0d cycles", $time, name, timeout_cycles);
      timeout_cnt++;
    end
  endtask

  // ------------------------------
  // AXI-Lite master tasks
  // ------------------------------
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    int hold;
    logic [31:0] r;
    hold = rand_word() % 4;
    r = rand_word();
    sh_ocl_awvalid = 1'b1;
    sh_ocl_awaddr  = addr;
    wait_flag(flag_awready, "awready");
    @(posedge clk_main_a0);
    #1;
    sh_ocl_awvalid = 1'b0;
    sh_ocl_wvalid  = 1'b1;
    sh_ocl_wdata   = data;
    sh_ocl_wstrb   = r[3:0];
    wait_flag(flag_wready, "wready");
    @(posedge clk_main_a0);
    #1;
    sh_ocl_wvalid = 1'b0;
    // Response held while bready is low
    wait_flag(flag_bvalid, "bvalid");
    if (ocl_sh_bresp !== 2'b00) begin
      $display("FAIL %0t: bresp %b, expected OKAY", $time, ocl_sh_bresp);
      mismatch_cnt++;
    end
    repeat (hold) @(posedge clk_main_a0);
    @(posedge clk_main_a0);
    #1;
    sh_ocl_bready = 1'b1;
    @(posedge clk_main_a0);
    #1;
    sh_ocl_bready = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    int hold;
    hold = rand_word() % 4;
    sh_ocl_arvalid = 1'b1;
    sh_ocl_araddr  = addr;
    wait_flag(flag_arready, "arready");
    @(posedge clk_main_a0);
    #1;
    sh_ocl_arvalid = 1'b0;
    wait_flag(flag_rvalid, "rvalid");
    data = ocl_sh_rdata;
    if (ocl_sh_rresp !== 2'b00) begin
      $display("FAIL %0t: rresp %b, expected OKAY", $time, ocl_sh_rresp);
      mismatch_cnt++;
    end
    repeat (hold) @(posedge clk_main_a0);
    @(posedge clk_main_a0);
    #1;
    sh_ocl_rready = 1'b1;
    @(posedge clk_main_a0);
    #1;
    sh_ocl_rready = 1'b0;
  endtask

  task automatic check_count(input logic [31:0] status, input logic [15:0] exp);
    if (status[15:0] !== exp) begin
      $display("FAIL %0t: status count %h, expected %h", $time, status[15:0], exp);
      mismatch_cnt++;
    end
  endtask

  // Only valid for reads taken with the counter stopped
  task automatic check_flag(input logic [31:0] status);
    if (status[24] !== (status[15:0] >= model_watermark)) begin
      $display("FAIL %0t: watermark flag %0b for count %h, watermark %h",
               $time, status[24], status[15:0], model_watermark);
      mismatch_cnt++;
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : main_seq
    logic [31:0] w;
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] a;
    int unsigned assert_cnt;
    int i;
    rng_state         = 32'h658a80bd;
    mismatch_cnt      = 0;
    timeout_cnt       = 0;
    model_hello       = '0;
    model_dip         = '0;
    model_watermark   = '0;
    rst_main_n_sync   = 1'b0;
    sh_ocl_awvalid    = 1'b0;
    sh_ocl_awaddr     = '0;
    sh_ocl_wvalid     = 1'b0;
    sh_ocl_wdata      = '0;
    sh_ocl_wstrb      = '0;
    sh_ocl_bready     = 1'b0;
    sh_ocl_arvalid    = 1'b0;
    sh_ocl_araddr     = '0;
    sh_ocl_rready     = 1'b0;
    sh_cl_status_vdip = '0;
    repeat (16) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
    @(posedge clk_main_a0);
    #1;

    // Byte swap on the hello register
    for (i = 0; i < 8; i++) begin
      w = rand_word();
      write_reg(cl_hello_pkg::hello_addr, w);
      model_hello = w;
      read_reg(cl_hello_pkg::hello_addr, r);
      if (r !== byte_swap(model_hello)) begin
        $display("FAIL %0t: hello read %h, expected %h", $time, r, byte_swap(model_hello));
        mismatch_cnt++;
      end
    end

    // LED output masked by the DIP input
    for (i = 0; i < 6; i++) begin
      w  = rand_word();
      r2 = rand_word();
      sh_cl_status_vdip = r2[15:0];
      model_dip         = r2[15:0];
      write_reg(cl_hello_pkg::hello_addr, w);
      model_hello = w;
      repeat (6) @(posedge clk_main_a0);
      #1;
      if (cl_sh_status_vled !== (model_hello[15:0] & model_dip)) begin
        $display("FAIL %0t: vled %h, expected %h", $time, cl_sh_status_vled,
                 model_hello[15:0] & model_dip);
        mismatch_cnt++;
      end
      read_reg(cl_hello_pkg::vled_addr, r);
      if (r !== {16'h0, model_hello[15:0]}) begin
        $display("FAIL %0t: LED register %h, expected %h", $time, r, model_hello[15:0]);
        mismatch_cnt++;
      end
    end

    // Unmapped addresses and register readback
    for (i = 0; i < 8; i++) begin
      a = rand_word();
      if (is_mapped(a)) begin
        a = a ^ 32'h8000_0000;
      end
      read_reg(a, r);
      if (r !== 32'hDEAD_DEAD) begin
        $display("FAIL %0t: unmapped %h read %h", $time, a, r);
        mismatch_cnt++;
      end
    end
    for (i = 0; i < 4; i++) begin
      w = rand_word();
      write_reg(cl_hello_pkg::cnt_ctrl_addr, w & 32'h7);
      read_reg(cl_hello_pkg::cnt_ctrl_addr, r);
      if (r !== {29'h0, w[2], 1'b0, w[0]}) begin
        $display("FAIL %0t: control read %h after write %h", $time, r, w & 32'h7);
        mismatch_cnt++;
      end
      w = rand_word();
      write_reg(cl_hello_pkg::tick_val_addr, w);
      read_reg(cl_hello_pkg::tick_val_addr, r);
      if (r !== {24'h0, w[7:0]}) begin
        $display("FAIL %0t: tick value read %h, expected %h", $time, r, w[7:0]);
        mismatch_cnt++;
      end
      w = rand_word();
      write_reg(cl_hello_pkg::watermark_addr, w);
      model_watermark = w[15:0];
      read_reg(cl_hello_pkg::watermark_addr, r);
      if (r !== {16'h0, model_watermark}) begin
        $display("FAIL %0t: watermark read %h, expected %h", $time, r, model_watermark);
        mismatch_cnt++;
      end
    end

    // Load, hold and clear with the counter stopped
    write_reg(cl_hello_pkg::cnt_ctrl_addr, 32'h0);
    for (i = 0; i < 4; i++) begin
      w = rand_word();
      write_reg(cl_hello_pkg::watermark_addr, {16'h0, w[31:16]});
      model_watermark = w[31:16];
      write_reg(cl_hello_pkg::cnt_load_addr, {16'h0, w[15:0]});
      read_reg(cl_hello_pkg::cnt_status_addr, r);
      read_reg(cl_hello_pkg::cnt_status_addr, r2);
      check_count(r, w[15:0]);
      check_count(r2, w[15:0]);
      check_flag(r);
      check_flag(r2);
    end
    write_reg(cl_hello_pkg::cnt_ctrl_addr, 32'h2);
    read_reg(cl_hello_pkg::cnt_status_addr, r);
    check_count(r, 16'h0);
    check_flag(r);

    // Free counting with a random prescaler
    for (i = 0; i < 4; i++) begin
      w = rand_word();
      write_reg(cl_hello_pkg::cnt_ctrl_addr, 32'h0);
      write_reg(cl_hello_pkg::tick_val_addr, {24'h0, w[7:0]});
      write_reg(cl_hello_pkg::cnt_load_addr, 32'h0);
      write_reg(cl_hello_pkg::cnt_ctrl_addr, 32'h1);
      read_reg(cl_hello_pkg::cnt_status_addr, r);
      read_reg(cl_hello_pkg::cnt_status_addr, r2);
      if (r2[15:0] < r[15:0]) begin
        $display("FAIL %0t: count went from %h to %h", $time, r[15:0], r2[15:0]);
        mismatch_cnt++;
      end
      write_reg(cl_hello_pkg::cnt_ctrl_addr, 32'h0);
      read_reg(cl_hello_pkg::cnt_status_addr, r);
      check_flag(r);
    end

    // One-shot saturates, plain mode wraps
    write_reg(cl_hello_pkg::tick_val_addr, 32'h0);
    write_reg(cl_hello_pkg::cnt_load_addr, 32'hFFF0);
    write_reg(cl_hello_pkg::cnt_ctrl_addr, 32'h5);
    repeat (40) @(posedge clk_main_a0);
    #1;
    read_reg(cl_hello_pkg::cnt_status_addr, r);
    check_count(r, 16'hFFFF);
    write_reg(cl_hello_pkg::cnt_ctrl_addr, 32'h0);
    write_reg(cl_hello_pkg::cnt_load_addr, 32'hFFF0);
    write_reg(cl_hello_pkg::cnt_ctrl_addr, 32'h1);
    repeat (40) @(posedge clk_main_a0);
    #1;
    read_reg(cl_hello_pkg::cnt_status_addr, r);
    if (r[15:0] >= 16'hFFF0) begin
      $display("FAIL %0t: count %h did not wrap", $time, r[15:0]);
      mismatch_cnt++;
    end
    write_reg(cl_hello_pkg::cnt_ctrl_addr, 32'h0);
    read_reg(cl_hello_pkg::cnt_status_addr, r);
    check_flag(r);

    assert_cnt = cl_hello_world_inst.cl_hello_world_assertions_inst.fail_cnt;
    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatch_cnt, timeout_cnt, assert_cnt);
    if (mismatch_cnt + timeout_cnt + assert_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
